//--- src/bus_pkg.sv
package bus_pkg;

    // high byte of the 0x9Fxx io area
    localparam logic [7:0] IO_PAGE = 8'h9F;
    // low memory lives in sram pages 0x170..0x17F
    localparam logic [4:0] LOWMEM_PAGE_BASE = 5'h17;
    // rom banks sit at the top of sram
    localparam logic [1:0] ROM_PREFIX = 2'b11;
    // boot into the internal boot rom
    localparam logic [5:0] ROMBANK_RESET = 6'd63;
    localparam int BOOTROM_BANK_BIT = 5;
    localparam int MST_ADDR_W = 24;
    localparam int MEM_ABH_W = 9;

    // debug master access sequence
    typedef enum logic [2:0] {
        MST_IDLE,
        MST_WAIT_STOP,
        MST_BUS_OFF,
        MST_SETUP,
        MST_EXT1,
        MST_EXT2,
        MST_DATA,
        MST_FIN
    } mst_state_e;

    // device selects, all active high here
    typedef struct packed {
        logic sram;
        logic vera;
        logic aio;
        logic enet;
        logic bootrom;
        logic scrb;
        logic via1;
        logic bankreg;
        // write strobe allowed (rom banks are read only)
        logic wr_ok;
    } dev_sel_t;

    // one decoded bus access
    typedef struct packed {
        logic valid;
        dev_sel_t sel;
        logic [MEM_ABH_W-1:0] mem_abh;
        logic [11:0] abl;
        logic [15:0] addr;
        logic rwn;
    } cpu_acc_t;

    // master address, flat sram view or region flags
    typedef union packed {
        struct packed {
            logic [MST_ADDR_W-22:0] pad;
            logic [20:0] sram_addr;
        } mem;
        struct packed {
            logic [MST_ADDR_W-22:0] pad;
            logic bootrom;
            logic bankreg;
            logic ioregs;
            logic [9:0] unused;
            logic [7:0] io_ofs;
        } region;
    } mst_addr_u;

    // one-cycle strobes from the master sequencer
    typedef struct packed {
        logic grab;
        logic setup;
        logic data;
        logic fin;
    } mst_phase_t;

    typedef struct packed {
        logic [7:0] rambank;
        logic [5:0] rombank;
    } bank_state_t;

    // rom selects the rombank register, else rambank
    typedef struct packed {
        logic en;
        logic rom;
        logic [7:0] data;
    } bank_wr_t;

    // decode of the low byte inside the io page
    function automatic dev_sel_t io_select(input logic [7:0] ofs);
        dev_sel_t sel;
        sel = '0;
        case (ofs[7:4])
            4'h0: sel.via1 = 1'b1;
            4'h2, 4'h3:
            begin
                sel.vera = 1'b1;
                sel.wr_ok = 1'b1;
            end
            // audio area always goes to the external aio chip
            4'h4:
            begin
                sel.aio = 1'b1;
                sel.wr_ok = 1'b1;
            end
            4'h5: sel.scrb = 1'b1;
            4'h8:
            begin
                sel.enet = 1'b1;
                sel.wr_ok = 1'b1;
            end
            default: sel = '0;
        endcase
        return sel;
    endfunction

endpackage

//--- src/cpu_map.sv
`timescale 1ns/100ps

module cpu_map (
    input  logic clk6x,
    input  logic resetn,
    // 1 = 65C02, 0 = 65C816
    input  logic cputype02_i,
    input  logic [3:0] cpu_abh_i,
    input  logic [11:0] memcpu_abl_i,
    input  logic cpu_rw_i,
    input  logic cpu_vda_i,
    input  logic cpu_sync_vpa_i,
    // vector pull, active low
    input  logic cpu_vpu_i,
    input  logic [7:0] rambank_mask_i,
    input  bus_pkg::bank_wr_t bank_wr_i,
    output bus_pkg::cpu_acc_t cpu_acc_o,
    output bus_pkg::bank_state_t bank_o
);

    bus_pkg::bank_state_t bank_q;
    logic [7:0] rambank_masked;
    logic [15:0] cpu_ab;
    logic [4:0] rom_field;

    // full cpu address from the two bus halves
    assign cpu_ab = {cpu_abh_i, memcpu_abl_i};
    assign bank_o = bank_q;

    // bank registers at 0x0000 / 0x0001
    always_ff @(posedge clk6x)
    begin
        if (!resetn)
        begin
            bank_q.rambank <= 8'h00;
            bank_q.rombank <= bus_pkg::ROMBANK_RESET;
        end
        else if (bank_wr_i.en)
        begin
            if (bank_wr_i.rom)
            begin
                bank_q.rombank <= bank_wr_i.data[5:0];
            end
            else
            begin
                bank_q.rambank <= bank_wr_i.data;
            end
        end
    end

    // masked ram bank, precomputed a cycle ahead
    always_ff @(posedge clk6x)
    begin
        rambank_masked <= bank_q.rambank & rambank_mask_i;
    end

    // vector pull always fetches from rom bank 0
    assign rom_field = cpu_vpu_i ? bank_q.rombank[4:0] : 5'd0;

    always_comb
    begin
        cpu_acc_o = '0;
        cpu_acc_o.addr = cpu_ab;
        cpu_acc_o.abl = memcpu_abl_i;
        cpu_acc_o.rwn = cpu_rw_i;
        // 65C02 cycles are always valid
        cpu_acc_o.valid = cputype02_i | cpu_vda_i | cpu_sync_vpa_i;
        if (cpu_acc_o.valid)
        begin
            if (cpu_ab[15:1] == 15'd0)
            begin
                cpu_acc_o.sel.bankreg = 1'b1;
            end
            else if (cpu_ab[15:14] == 2'b11)
            begin
                // 16k rom window
                if (bank_q.rombank[bus_pkg::BOOTROM_BANK_BIT])
                begin
                    cpu_acc_o.sel.bootrom = 1'b1;
                end
                else
                begin
                    cpu_acc_o.mem_abh = {bus_pkg::ROM_PREFIX, rom_field, cpu_ab[13:12]};
                    cpu_acc_o.sel.sram = 1'b1;
                end
            end
            else if (cpu_ab[15:13] == 3'b101)
            begin
                // 8k ram window
                cpu_acc_o.mem_abh = {rambank_masked, cpu_ab[12]};
                cpu_acc_o.sel.sram = 1'b1;
                cpu_acc_o.sel.wr_ok = 1'b1;
            end
            else if (cpu_ab[15:8] == bus_pkg::IO_PAGE)
            begin
                cpu_acc_o.sel = bus_pkg::io_select(cpu_ab[7:0]);
            end
            else
            begin
                // rest of low memory
                cpu_acc_o.mem_abh = {bus_pkg::LOWMEM_PAGE_BASE, cpu_ab[15:12]};
                cpu_acc_o.sel.sram = 1'b1;
                cpu_acc_o.sel.wr_ok = 1'b1;
            end
        end
    end

endmodule

//--- src/mst_sequencer.sv
`timescale 1ns/100ps

module mst_sequencer (
    input  logic clk6x,
    input  logic resetn,
    input  bus_pkg::mst_addr_u mst_addr_i,
    input  logic mst_req_sram_i,
    input  logic mst_req_other_i,
    input  logic mst_rwn_i,
    input  logic stopped_cpu_i,
    output logic run_cpu_o,
    output logic cpu_be_o,
    output logic mst_ack_o,
    output bus_pkg::mst_phase_t phase_o,
    output bus_pkg::cpu_acc_t mst_acc_o
);

    bus_pkg::mst_state_e state;
    logic req;

    assign req = mst_req_sram_i | mst_req_other_i;

    always_ff @(posedge clk6x)
    begin
        if (!resetn)
        begin
            state <= bus_pkg::MST_IDLE;
            run_cpu_o <= 1'b0;
            cpu_be_o <= 1'b1;
            mst_ack_o <= 1'b0;
        end
        else
        begin
            case (state)
                bus_pkg::MST_IDLE:
                begin
                    run_cpu_o <= 1'b1;
                    mst_ack_o <= 1'b0;
                    // no new request while the ack pulse is still out
                    if (req && !mst_ack_o)
                    begin
                        run_cpu_o <= 1'b0;
                        state <= bus_pkg::MST_WAIT_STOP;
                    end
                end
                bus_pkg::MST_WAIT_STOP:
                begin
                    // phaser parks the cpu, then float its bus
                    if (stopped_cpu_i)
                    begin
                        cpu_be_o <= 1'b0;
                        state <= bus_pkg::MST_BUS_OFF;
                    end
                end
                // bus turnaround, address goes out here
                bus_pkg::MST_BUS_OFF: state <= bus_pkg::MST_SETUP;
                bus_pkg::MST_SETUP: state <= bus_pkg::MST_EXT1;
                // two cycles of device access time
                bus_pkg::MST_EXT1: state <= bus_pkg::MST_EXT2;
                bus_pkg::MST_EXT2: state <= bus_pkg::MST_DATA;
                bus_pkg::MST_DATA: state <= bus_pkg::MST_FIN;
                bus_pkg::MST_FIN:
                begin
                    mst_ack_o <= 1'b1;
                    cpu_be_o <= 1'b1;
                    state <= bus_pkg::MST_IDLE;
                end
                default: state <= bus_pkg::MST_IDLE;
            endcase
        end
    end

    // phase strobes are plain state decodes
    always_comb
    begin
        phase_o.grab = (state == bus_pkg::MST_BUS_OFF);
        phase_o.setup = (state == bus_pkg::MST_SETUP);
        phase_o.data = (state == bus_pkg::MST_DATA);
        phase_o.fin = (state == bus_pkg::MST_FIN);
    end

    // master access descriptor
    always_comb
    begin
        mst_acc_o = '0;
        mst_acc_o.valid = req;
        mst_acc_o.rwn = mst_rwn_i;
        mst_acc_o.addr = mst_addr_i.mem.sram_addr[15:0];
        mst_acc_o.abl = mst_addr_i.mem.sram_addr[11:0];
        mst_acc_o.mem_abh = mst_addr_i.mem.sram_addr[20:12];
        if (mst_req_sram_i)
        begin
            mst_acc_o.sel.sram = 1'b1;
            mst_acc_o.sel.wr_ok = 1'b1;
        end
        else if (mst_req_other_i)
        begin
            // io offset decoded just like a cpu access
            if (mst_addr_i.region.ioregs)
            begin
                mst_acc_o.sel = bus_pkg::io_select(mst_addr_i.region.io_ofs);
            end
            mst_acc_o.sel.bootrom = mst_acc_o.sel.bootrom | mst_addr_i.region.bootrom;
            mst_acc_o.sel.bankreg = mst_acc_o.sel.bankreg | mst_addr_i.region.bankreg;
        end
    end

endmodule

//--- src/bus_drive.sv
`timescale 1ns/100ps

module bus_drive (
    input  logic clk6x,
    input  logic resetn,
    input  bus_pkg::cpu_acc_t cpu_acc_i,
    input  bus_pkg::cpu_acc_t mst_acc_i,
    input  bus_pkg::mst_phase_t phase_i,
    input  bus_pkg::bank_state_t bank_i,
    input  logic setup_cs_i,
    input  logic release_wr_i,
    input  logic release_cs_i,
    input  logic [7:0] mem_db_i,
    input  logic [7:0] cpu_db_i,
    input  logic [7:0] slv_data_i,
    input  logic [7:0] mst_data_i,
    output logic sram_csn_o,
    output logic vera_csn_o,
    output logic aio_csn_o,
    output logic enet_csn_o,
    output logic mem_rdn_o,
    output logic mem_wrn_o,
    output logic [bus_pkg::MEM_ABH_W-1:0] mem_abh_o,
    output logic [11:0] memcpu_abl_o,
    output logic [15:0] slv_addr_o,
    output logic slv_rwn_o,
    output logic slv_req_bootrom_o,
    output logic slv_req_scrb_o,
    output logic slv_req_via1_o,
    output logic [7:0] slv_datawr_o,
    output logic slv_datawr_valid_o,
    output logic [7:0] cpu_db_o,
    output logic [7:0] mst_datard_o,
    output bus_pkg::bank_wr_t bank_wr_o
);

    bus_pkg::cpu_acc_t acc_in;
    bus_pkg::dev_sel_t sel_q;
    logic load;
    logic rel_wr;
    logic rel_cs;
    logic ext_in;
    logic ext_q;
    logic rwn_q;
    logic wr_act;
    logic mst_drv;
    logic [15:0] addr_q;
    logic [7:0] wr_data;

    // cpu cycle starts on setup_cs, master access on its setup phase
    assign load = setup_cs_i | phase_i.setup;
    assign acc_in = phase_i.setup ? mst_acc_i : cpu_acc_i;
    assign rel_wr = release_wr_i | phase_i.data;
    assign rel_cs = release_cs_i | phase_i.fin;

    // external chip selects only
    assign ext_in = acc_in.sel.sram | acc_in.sel.vera | acc_in.sel.aio | acc_in.sel.enet;
    assign ext_q = sel_q.sram | sel_q.vera | sel_q.aio | sel_q.enet;

    always_ff @(posedge clk6x)
    begin
        if (!resetn)
        begin
            sel_q <= '0;
            rwn_q <= 1'b1;
            wr_act <= 1'b0;
            mst_drv <= 1'b0;
        end
        else
        begin
            if (load)
            begin
                // invalid 65C816 cycle selects nothing
                sel_q <= acc_in.valid ? acc_in.sel : '0;
                rwn_q <= acc_in.rwn;
                wr_act <= acc_in.valid & ext_in & ~acc_in.rwn & acc_in.sel.wr_ok;
            end
            // write strobe ends before the chip select for hold time
            if (rel_wr)
            begin
                wr_act <= 1'b0;
            end
            if (rel_cs)
            begin
                sel_q <= '0;
                wr_act <= 1'b0;
            end
            // master owns the write data from grab to fin
            if (phase_i.grab)
            begin
                mst_drv <= 1'b1;
            end
            else if (phase_i.fin)
            begin
                mst_drv <= 1'b0;
            end
        end
    end

    // address path
    always_ff @(posedge clk6x)
    begin
        if (load)
        begin
            addr_q <= acc_in.addr;
            mem_abh_o <= acc_in.mem_abh;
            memcpu_abl_o <= acc_in.abl;
        end
        else if (phase_i.grab)
        begin
            // master address goes out once the cpu bus floats
            mem_abh_o <= mst_acc_i.mem_abh;
            memcpu_abl_o <= mst_acc_i.abl;
        end
    end

    // read data back to cpu and master
    always_ff @(posedge clk6x)
    begin
        if (!mem_rdn_o)
        begin
            cpu_db_o <= mem_db_i;
        end
        else if (sel_q.bankreg)
        begin
            cpu_db_o <= addr_q[0] ? {2'b00, bank_i.rombank} : bank_i.rambank;
        end
        else if (sel_q.bootrom | sel_q.scrb | sel_q.via1)
        begin
            cpu_db_o <= slv_data_i;
        end
        if (phase_i.data)
        begin
            mst_datard_o <= cpu_db_o;
        end
    end

    // active low pins
    assign sram_csn_o = ~sel_q.sram;
    assign vera_csn_o = ~sel_q.vera;
    assign aio_csn_o = ~sel_q.aio;
    assign enet_csn_o = ~sel_q.enet;
    assign mem_rdn_o = ~(ext_q & rwn_q);
    assign mem_wrn_o = ~wr_act;

    // internal slave side
    assign slv_addr_o = addr_q;
    assign slv_rwn_o = rwn_q;
    assign slv_req_bootrom_o = sel_q.bootrom;
    assign slv_req_scrb_o = sel_q.scrb;
    assign slv_req_via1_o = sel_q.via1;

    // cpu write data is only stable at the end of its cycle
    assign wr_data = mst_drv ? mst_data_i : cpu_db_i;
    assign slv_datawr_o = wr_data;
    assign slv_datawr_valid_o = rel_wr;

    // bank register write lands on the release edge
    always_comb
    begin
        bank_wr_o.en = rel_wr & sel_q.bankreg & ~rwn_q;
        bank_wr_o.rom = addr_q[0];
        bank_wr_o.data = wr_data;
    end

endmodule

//--- src/bus_controller.sv
`timescale 1ns/100ps

module bus_controller (
    input  logic clk6x,
    input  logic resetn,
    input  logic cputype02_i,
    // cpu bus
    input  logic [3:0] cpu_abh_i,
    input  logic [11:0] memcpu_abl_i,
    input  logic [7:0] cpu_db_i,
    output logic [7:0] cpu_db_o,
    output logic cpu_be_o,
    input  logic cpu_rw_i,
    input  logic cpu_vda_i,
    input  logic cpu_sync_vpa_i,
    input  logic cpu_vpu_i,
    // memory bus
    output logic [bus_pkg::MEM_ABH_W-1:0] mem_abh_o,
    output logic [11:0] memcpu_abl_o,
    input  logic [7:0] mem_db_i,
    output logic mem_rdn_o,
    output logic mem_wrn_o,
    output logic sram_csn_o,
    output logic vera_csn_o,
    output logic aio_csn_o,
    output logic enet_csn_o,
    // phaser
    input  logic setup_cs_i,
    input  logic release_wr_i,
    input  logic release_cs_i,
    output logic run_cpu_o,
    input  logic stopped_cpu_i,
    // debug master
    input  bus_pkg::mst_addr_u mst_addr_i,
    input  logic [7:0] mst_data_i,
    output logic [7:0] mst_datard_o,
    output logic mst_ack_o,
    input  logic mst_req_sram_i,
    input  logic mst_req_other_i,
    input  logic mst_rwn_i,
    // internal slaves
    output logic [15:0] slv_addr_o,
    output logic [7:0] slv_datawr_o,
    output logic slv_datawr_valid_o,
    input  logic [7:0] slv_data_i,
    output logic slv_req_bootrom_o,
    output logic slv_req_scrb_o,
    output logic slv_req_via1_o,
    output logic slv_rwn_o,
    input  logic [7:0] rambank_mask_i
);

    bus_pkg::cpu_acc_t cpu_acc;
    bus_pkg::cpu_acc_t mst_acc;
    bus_pkg::mst_phase_t phase;
    bus_pkg::bank_state_t bank;
    bus_pkg::bank_wr_t bank_wr;

    cpu_map u_cpu_map (
        .clk6x(clk6x),
        .resetn(resetn),
        .cputype02_i(cputype02_i),
        .cpu_abh_i(cpu_abh_i),
        .memcpu_abl_i(memcpu_abl_i),
        .cpu_rw_i(cpu_rw_i),
        .cpu_vda_i(cpu_vda_i),
        .cpu_sync_vpa_i(cpu_sync_vpa_i),
        .cpu_vpu_i(cpu_vpu_i),
        .rambank_mask_i(rambank_mask_i),
        .bank_wr_i(bank_wr),
        .cpu_acc_o(cpu_acc),
        .bank_o(bank)
    );

    mst_sequencer u_mst_sequencer (
        .clk6x(clk6x),
        .resetn(resetn),
        .mst_addr_i(mst_addr_i),
        .mst_req_sram_i(mst_req_sram_i),
        .mst_req_other_i(mst_req_other_i),
        .mst_rwn_i(mst_rwn_i),
        .stopped_cpu_i(stopped_cpu_i),
        .run_cpu_o(run_cpu_o),
        .cpu_be_o(cpu_be_o),
        .mst_ack_o(mst_ack_o),
        .phase_o(phase),
        .mst_acc_o(mst_acc)
    );

    bus_drive u_bus_drive (
        .clk6x(clk6x),
        .resetn(resetn),
        .cpu_acc_i(cpu_acc),
        .mst_acc_i(mst_acc),
        .phase_i(phase),
        .bank_i(bank),
        .setup_cs_i(setup_cs_i),
        .release_wr_i(release_wr_i),
        .release_cs_i(release_cs_i),
        .mem_db_i(mem_db_i),
        .cpu_db_i(cpu_db_i),
        .slv_data_i(slv_data_i),
        .mst_data_i(mst_data_i),
        .sram_csn_o(sram_csn_o),
        .vera_csn_o(vera_csn_o),
        .aio_csn_o(aio_csn_o),
        .enet_csn_o(enet_csn_o),
        .mem_rdn_o(mem_rdn_o),
        .mem_wrn_o(mem_wrn_o),
        .mem_abh_o(mem_abh_o),
        .memcpu_abl_o(memcpu_abl_o),
        .slv_addr_o(slv_addr_o),
        .slv_rwn_o(slv_rwn_o),
        .slv_req_bootrom_o(slv_req_bootrom_o),
        .slv_req_scrb_o(slv_req_scrb_o),
        .slv_req_via1_o(slv_req_via1_o),
        .slv_datawr_o(slv_datawr_o),
        .slv_datawr_valid_o(slv_datawr_valid_o),
        .cpu_db_o(cpu_db_o),
        .mst_datard_o(mst_datard_o),
        .bank_wr_o(bank_wr)
    );

endmodule

//--- tests/tb_bus_controller.sv
`timescale 1ns/100ps

module tb_bus_controller;

    // row kinds cover plain cpu cycles, vector pulls, invalid 65C816 cycles and master accesses
    localparam logic [2:0] K_CPU = 3'd0;
    localparam logic [2:0] K_VEC = 3'd1;
    localparam logic [2:0] K_INV = 3'd2;
    localparam logic [2:0] K_MRAM = 3'd3;
    localparam logic [2:0] K_MBANK = 3'd4;
    // chip select vector order is sram, vera, aio, enet (active low)
    localparam logic [3:0] CS_NONE = 4'b1111;
    localparam logic [3:0] CS_SRAM = 4'b0111;
    localparam logic [3:0] CS_VERA = 4'b1011;
    localparam logic [3:0] CS_AIO = 4'b1101;
    localparam logic [3:0] CS_ENET = 4'b1110;
    // slave request vector order is bootrom, scrb, via1
    localparam logic [2:0] SL_NONE = 3'b000;
    localparam logic [2:0] SL_BOOT = 3'b100;
    localparam logic [2:0] SL_SCRB = 3'b010;
    localparam logic [2:0] SL_VIA1 = 3'b001;
    localparam logic [7:0] RAM_MASK = 8'h3f;
    localparam int NUM_STEPS = 26;
    localparam int RESET_CYCLES = 8;
    localparam int CYCLE_LIMIT = 40 * NUM_STEPS + RESET_CYCLES;
    localparam int ACK_WAIT = 30;

    // one table row
    // chk bit 1 enables the mem_abh_o check and bit 0 the read data check
    typedef struct packed {
        logic [2:0] kind;
        logic [23:0] addr;
        logic rwn;
        logic [7:0] wdata;
        logic [3:0] exp_csn;
        logic [2:0] exp_slv;
        logic exp_wrn;
        logic [8:0] exp_abh;
        logic [7:0] exp_rd;
        logic [1:0] chk;
    } step_t;

    logic clk6x;
    logic resetn;
    logic cputype02_i;
    logic [3:0] cpu_abh_i;
    logic [11:0] memcpu_abl_i;
    logic [7:0] cpu_db_i;
    logic [7:0] cpu_db_o;
    logic cpu_be_o;
    logic cpu_rw_i;
    logic cpu_vda_i;
    logic cpu_sync_vpa_i;
    logic cpu_vpu_i;
    logic [bus_pkg::MEM_ABH_W-1:0] mem_abh_o;
    logic [11:0] memcpu_abl_o;
    logic [7:0] mem_db_i;
    logic mem_rdn_o;
    logic mem_wrn_o;
    logic sram_csn_o;
    logic vera_csn_o;
    logic aio_csn_o;
    logic enet_csn_o;
    logic setup_cs_i;
    logic release_wr_i;
    logic release_cs_i;
    logic run_cpu_o;
    logic stopped_cpu_i;
    bus_pkg::mst_addr_u mst_addr_i;
    logic [7:0] mst_data_i;
    logic [7:0] mst_datard_o;
    logic mst_ack_o;
    logic mst_req_sram_i;
    logic mst_req_other_i;
    logic mst_rwn_i;
    logic [15:0] slv_addr_o;
    logic [7:0] slv_datawr_o;
    logic slv_datawr_valid_o;
    logic [7:0] slv_data_i;
    logic slv_req_bootrom_o;
    logic slv_req_scrb_o;
    logic slv_req_via1_o;
    logic slv_rwn_o;
    logic [7:0] rambank_mask_i;

    step_t steps [0:NUM_STEPS-1];
    int n_steps;
    int cycle_cnt;
    logic [1:0] stop_delay;
    integer seed;

    bus_controller uut (
        .clk6x(clk6x),
        .resetn(resetn),
        .cputype02_i(cputype02_i),
        .cpu_abh_i(cpu_abh_i),
        .memcpu_abl_i(memcpu_abl_i),
        .cpu_db_i(cpu_db_i),
        .cpu_db_o(cpu_db_o),
        .cpu_be_o(cpu_be_o),
        .cpu_rw_i(cpu_rw_i),
        .cpu_vda_i(cpu_vda_i),
        .cpu_sync_vpa_i(cpu_sync_vpa_i),
        .cpu_vpu_i(cpu_vpu_i),
        .mem_abh_o(mem_abh_o),
        .memcpu_abl_o(memcpu_abl_o),
        .mem_db_i(mem_db_i),
        .mem_rdn_o(mem_rdn_o),
        .mem_wrn_o(mem_wrn_o),
        .sram_csn_o(sram_csn_o),
        .vera_csn_o(vera_csn_o),
        .aio_csn_o(aio_csn_o),
        .enet_csn_o(enet_csn_o),
        .setup_cs_i(setup_cs_i),
        .release_wr_i(release_wr_i),
        .release_cs_i(release_cs_i),
        .run_cpu_o(run_cpu_o),
        .stopped_cpu_i(stopped_cpu_i),
        .mst_addr_i(mst_addr_i),
        .mst_data_i(mst_data_i),
        .mst_datard_o(mst_datard_o),
        .mst_ack_o(mst_ack_o),
        .mst_req_sram_i(mst_req_sram_i),
        .mst_req_other_i(mst_req_other_i),
        .mst_rwn_i(mst_rwn_i),
        .slv_addr_o(slv_addr_o),
        .slv_datawr_o(slv_datawr_o),
        .slv_datawr_valid_o(slv_datawr_valid_o),
        .slv_data_i(slv_data_i),
        .slv_req_bootrom_o(slv_req_bootrom_o),
        .slv_req_scrb_o(slv_req_scrb_o),
        .slv_req_via1_o(slv_req_via1_o),
        .slv_rwn_o(slv_rwn_o),
        .rambank_mask_i(rambank_mask_i)
    );

    always #10 clk6x = ~clk6x;

    // memory contents depend on every page bit
    function automatic logic [7:0] mem_byte(input logic [8:0] abh);
        return abh[7:0] ^ {abh[8], abh[8:2]} ^ 8'h5c;
    endfunction

    // internal slave read data from the full slave address
    function automatic logic [7:0] slv_byte(input logic [15:0] addr);
        return addr[15:8] ^ addr[7:0] ^ 8'ha6;
    endfunction

    // memory and slave models answer on the falling edge
    always @(negedge clk6x)
    begin
        mem_db_i <= mem_byte(mem_abh_o);
        slv_data_i <= slv_byte(slv_addr_o);
    end

    // phaser parks the cpu a couple of cycles after run_cpu_o drops
    always @(negedge clk6x)
    begin
        if (run_cpu_o)
        begin
            stop_delay <= 2'd0;
            stopped_cpu_i <= 1'b0;
        end
        else if (stop_delay == 2'd2)
        begin
            stopped_cpu_i <= 1'b1;
        end
        else
        begin
            stop_delay <= stop_delay + 2'd1;
        end
    end

    // run limit from the table length
    always @(posedge clk6x)
    begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt >= CYCLE_LIMIT)
        begin
            $display("timeout: run went past %0d clock cycles", CYCLE_LIMIT);
            $display("sim failed");
            $fatal(1);
        end
    end

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        assert (got === exp)
        else
        begin
            $display("MISMATCH %s: got 0x%0h, expected 0x%0h", name, got, exp);
            $display("sim failed");
            $fatal(1);
        end
    endtask

    task automatic check_true(input logic cond, input string what);
        assert (cond === 1'b1)
        else
        begin
            $display("ERROR: %s", what);
            $display("sim failed");
            $fatal(1);
        end
    endtask

    task automatic add_row(input logic [2:0] kind, input logic [23:0] addr, input logic rwn,
                           input logic [7:0] wdata, input logic [3:0] exp_csn,
                           input logic [2:0] exp_slv, input logic exp_wrn,
                           input logic [8:0] exp_abh, input logic [7:0] exp_rd,
                           input logic [1:0] chk);
        step_t s;
        s.kind = kind;
        s.addr = addr;
        s.rwn = rwn;
        s.wdata = wdata;
        s.exp_csn = exp_csn;
        s.exp_slv = exp_slv;
        s.exp_wrn = exp_wrn;
        s.exp_abh = exp_abh;
        s.exp_rd = exp_rd;
        s.chk = chk;
        steps[n_steps] = s;
        n_steps = n_steps + 1;
    endtask

    task automatic build_table;
        logic [23:0] maddr;
        logic [7:0] bdata;
        logic [8:0] page;
        n_steps = 0;
        // rom bank 63 boots from the internal boot rom
        add_row(K_CPU, 24'hc000, 1, 8'h00, CS_NONE, SL_BOOT, 1, 9'h000,
                slv_byte(16'hc000), 2'b01);
        // ram bank 0xa5 maps to page 0x25 through the mask
        add_row(K_CPU, 24'h0000, 0, 8'ha5, CS_NONE, SL_NONE, 1, 9'h000, 8'h00, 2'b00);
        add_row(K_CPU, 24'h0000, 1, 8'h00, CS_NONE, SL_NONE, 1, 9'h000, 8'ha5, 2'b01);
        add_row(K_CPU, 24'ha000, 1, 8'h00, CS_SRAM, SL_NONE, 1, 9'h04a, mem_byte(9'h04a), 2'b11);
        add_row(K_CPU, 24'hb000, 0, 8'h11, CS_SRAM, SL_NONE, 0, 9'h04b, 8'h00, 2'b10);
        // rom bank 5 maps to page {11, 00101, ab13:12}
        add_row(K_CPU, 24'h0001, 0, 8'h05, CS_NONE, SL_NONE, 1, 9'h000, 8'h00, 2'b00);
        add_row(K_CPU, 24'h0001, 1, 8'h00, CS_NONE, SL_NONE, 1, 9'h000, 8'h05, 2'b01);
        add_row(K_CPU, 24'hc000, 1, 8'h00, CS_SRAM, SL_NONE, 1, 9'h194, mem_byte(9'h194), 2'b11);
        add_row(K_CPU, 24'hd000, 1, 8'h00, CS_SRAM, SL_NONE, 1, 9'h195, mem_byte(9'h195), 2'b11);
        add_row(K_CPU, 24'he000, 1, 8'h00, CS_SRAM, SL_NONE, 1, 9'h196, mem_byte(9'h196), 2'b11);
        // vector pull forces bank field 0
        add_row(K_VEC, 24'hf000, 1, 8'h00, CS_SRAM, SL_NONE, 1, 9'h183, mem_byte(9'h183), 2'b11);
        // rom window is read only
        add_row(K_CPU, 24'hf000, 0, 8'h77, CS_SRAM, SL_NONE, 1, 9'h197, 8'h00, 2'b10);
        // io page
        add_row(K_CPU, 24'h9f20, 1, 8'h00, CS_VERA, SL_NONE, 1, 9'h000, 8'h00, 2'b00);
        add_row(K_CPU, 24'h9f30, 0, 8'h3c, CS_VERA, SL_NONE, 0, 9'h000, 8'h00, 2'b00);
        add_row(K_CPU, 24'h9f40, 1, 8'h00, CS_AIO, SL_NONE, 1, 9'h000, 8'h00, 2'b00);
        add_row(K_CPU, 24'h9f80, 1, 8'h00, CS_ENET, SL_NONE, 1, 9'h000, 8'h00, 2'b00);
        add_row(K_CPU, 24'h9f00, 1, 8'h00, CS_NONE, SL_VIA1, 1, 9'h000,
                slv_byte(16'h9f00), 2'b01);
        add_row(K_CPU, 24'h9f50, 1, 8'h00, CS_NONE, SL_SCRB, 1, 9'h000,
                slv_byte(16'h9f50), 2'b01);
        // low memory pages 0x17x
        add_row(K_CPU, 24'h1000, 1, 8'h00, CS_SRAM, SL_NONE, 1, 9'h171, mem_byte(9'h171), 2'b11);
        add_row(K_CPU, 24'h8000, 0, 8'h42, CS_SRAM, SL_NONE, 0, 9'h178, 8'h00, 2'b10);
        // invalid cycle without vda or vpa gives no strobes
        add_row(K_INV, 24'h2000, 1, 8'h00, CS_NONE, SL_NONE, 1, 9'h000, 8'h00, 2'b00);
        // master sram reads at random addresses
        maddr = $random(seed) & 24'h1f_ffff;
        add_row(K_MRAM, maddr, 1, 8'h00, CS_NONE, SL_NONE, 1, maddr[20:12],
                mem_byte(maddr[20:12]), 2'b11);
        maddr = $random(seed) & 24'h1f_ffff;
        add_row(K_MRAM, maddr, 1, 8'h00, CS_NONE, SL_NONE, 1, maddr[20:12],
                mem_byte(maddr[20:12]), 2'b11);
        // master writes the ram bank through the bankreg region flag
        bdata = $random(seed);
        page = {bdata & RAM_MASK, 1'b0};
        add_row(K_MBANK, 24'h08_0000, 0, bdata, CS_NONE, SL_NONE, 1, 9'h000, 8'h00, 2'b00);
        add_row(K_CPU, 24'h0000, 1, 8'h00, CS_NONE, SL_NONE, 1, 9'h000, bdata, 2'b01);
        add_row(K_CPU, 24'ha000, 1, 8'h00, CS_SRAM, SL_NONE, 1, page, mem_byte(page), 2'b11);
    endtask

    task automatic check_selects(input step_t s);
        check_value("chip selects", {sram_csn_o, vera_csn_o, aio_csn_o, enet_csn_o},
                    s.exp_csn);
        check_value("slave requests", {slv_req_bootrom_o, slv_req_scrb_o, slv_req_via1_o},
                    s.exp_slv);
        check_value("mem_wrn_o", mem_wrn_o, s.exp_wrn);
        // low address and slave side follow the latched access
        check_value("memcpu_abl_o", memcpu_abl_o, s.addr[11:0]);
        check_value("slv_addr_o", slv_addr_o, s.addr[15:0]);
        check_value("slv_rwn_o", slv_rwn_o, s.rwn);
        if (s.chk[1])
        begin
            check_value("mem_abh_o", mem_abh_o, s.exp_abh);
        end
    endtask

    // phaser plays setup_cs, two idle cycles, release_wr and release_cs
    task automatic run_cpu_cycle(input step_t s);
        @(negedge clk6x);
        cpu_abh_i = s.addr[15:12];
        memcpu_abl_i = s.addr[11:0];
        cpu_rw_i = s.rwn;
        cpu_vpu_i = (s.kind != K_VEC);
        cpu_vda_i = (s.kind != K_INV);
        cpu_db_i = s.wdata;
        setup_cs_i = 1'b1;
        @(negedge clk6x);
        setup_cs_i = 1'b0;
        @(negedge clk6x);
        @(negedge clk6x);
        // everything settled by mid cycle
        check_selects(s);
        check_value("mem_rdn_o", mem_rdn_o, !(s.rwn && s.exp_csn != CS_NONE));
        if (s.chk[0])
        begin
            check_value("cpu_db_o", cpu_db_o, s.exp_rd);
        end
        check_value("slv_datawr_o", slv_datawr_o, s.wdata);
        check_value("slv_datawr_valid_o", slv_datawr_valid_o, 1'b0);
        release_wr_i = 1'b1;
        // slave write strobe follows release_wr
        #1;
        check_value("slv_datawr_valid_o", slv_datawr_valid_o, 1'b1);
        @(negedge clk6x);
        release_wr_i = 1'b0;
        release_cs_i = 1'b1;
        @(negedge clk6x);
        release_cs_i = 1'b0;
        // cycle closed
        check_value("chip selects", {sram_csn_o, vera_csn_o, aio_csn_o, enet_csn_o}, CS_NONE);
        check_value("mem_wrn_o", mem_wrn_o, 1'b1);
        check_value("slave requests", {slv_req_bootrom_o, slv_req_scrb_o, slv_req_via1_o},
                    SL_NONE);
    endtask

    // request held until the ack pulse
    task automatic run_master_access(input step_t s);
        logic be_low;
        int waited;
        be_low = 1'b0;
        waited = 0;
        @(negedge clk6x);
        mst_addr_i = s.addr;
        mst_rwn_i = s.rwn;
        mst_data_i = s.wdata;
        mst_req_sram_i = (s.kind == K_MRAM);
        mst_req_other_i = (s.kind == K_MBANK);
        while (!mst_ack_o && waited < ACK_WAIT)
        begin
            @(negedge clk6x);
            waited = waited + 1;
            if (!cpu_be_o)
            begin
                be_low = 1'b1;
            end
        end
        check_true(mst_ack_o, "master access got no ack in time");
        mst_req_sram_i = 1'b0;
        mst_req_other_i = 1'b0;
        check_true(be_low, "cpu_be_o stayed high during the master access");
        check_value("cpu_be_o", cpu_be_o, 1'b1);
        check_selects(s);
        if (s.chk[0])
        begin
            check_value("mst_datard_o", mst_datard_o, s.exp_rd);
        end
        // ack lasts one cycle
        @(negedge clk6x);
        check_value("mst_ack_o", mst_ack_o, 1'b0);
    endtask

    initial
    begin
        seed = 32'ha105_97d9;
        cycle_cnt = 0;
        stop_delay = 2'd0;
        clk6x = 1'b0;
        resetn = 1'b0;
        cputype02_i = 1'b0;
        cpu_abh_i = 4'h0;
        memcpu_abl_i = 12'h000;
        cpu_db_i = 8'h00;
        cpu_rw_i = 1'b1;
        cpu_vda_i = 1'b1;
        cpu_sync_vpa_i = 1'b0;
        cpu_vpu_i = 1'b1;
        mem_db_i = 8'h00;
        setup_cs_i = 1'b0;
        release_wr_i = 1'b0;
        release_cs_i = 1'b0;
        stopped_cpu_i = 1'b0;
        mst_addr_i = '0;
        mst_data_i = 8'h00;
        mst_req_sram_i = 1'b0;
        mst_req_other_i = 1'b0;
        mst_rwn_i = 1'b1;
        slv_data_i = 8'h00;
        rambank_mask_i = RAM_MASK;
        build_table();
        repeat (RESET_CYCLES) @(negedge clk6x);
        // reset state of the outer pins
        check_value("chip selects", {sram_csn_o, vera_csn_o, aio_csn_o, enet_csn_o}, CS_NONE);
        check_value("mem_rdn_o", mem_rdn_o, 1'b1);
        check_value("mem_wrn_o", mem_wrn_o, 1'b1);
        check_value("cpu_be_o", cpu_be_o, 1'b1);
        check_value("mst_ack_o", mst_ack_o, 1'b0);
        check_value("run_cpu_o", run_cpu_o, 1'b0);
        check_value("slave requests", {slv_req_bootrom_o, slv_req_scrb_o, slv_req_via1_o},
                    SL_NONE);
        resetn = 1'b1;
        @(negedge clk6x);
        // idle lets the cpu run
        check_value("run_cpu_o", run_cpu_o, 1'b1);
        check_value("cpu_be_o", cpu_be_o, 1'b1);
        for (int i = 0; i < n_steps; i++)
        begin
            if (steps[i].kind == K_MRAM || steps[i].kind == K_MBANK)
            begin
                run_master_access(steps[i]);
            end
            else
            begin
                run_cpu_cycle(steps[i]);
            end
        end
        $display("sim passed");
        $finish;
    end

endmodule

//--- list.f
src/bus_pkg.sv
src/cpu_map.sv
src/mst_sequencer.sv
src/bus_drive.sv
src/bus_controller.sv
tests/tb_bus_controller.sv

//--- Bender.yml
package:
  name: bus_controller

sources:
  - src/bus_pkg.sv
  - src/cpu_map.sv
  - src/mst_sequencer.sv
  - src/bus_drive.sv
  - src/bus_controller.sv
  - target: test
    files:
      - tests/tb_bus_controller.sv
